// ==== common/axi_tap_pkg.sv ====
package axi_tap_pkg;

  // field widths of the AXI address and response channels
  localparam int id_width    = 4;
  localparam int addr_width  = 32;
  localparam int len_width   = 8;
  localparam int size_width  = 3;
  localparam int burst_width = 2;
  localparam int resp_width  = 2;

  // one beat of AR or AW
  // the two address channels carry the same fields, so one type serves both
  typedef struct packed {
    logic [id_width-1:0]    id;
    logic [addr_width-1:0]  addr;
    logic [len_width-1:0]   len;
    logic [size_width-1:0]  size;
    logic [burst_width-1:0] burst;
  } axi_addr_t;

  // one write response on B
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [resp_width-1:0] resp;
  } axi_resp_t;

endpackage

// ==== common/stream_pkg.sv ====
package stream_pkg;

  // tag of every record on the stream
  // the same value picks the tap inside the arbiter
  typedef enum logic [1:0] {
    chan_ar = 2'd0,
    chan_aw = 2'd1,
    chan_b  = 2'd2
  } channel_t;

  localparam int num_channels = 3;

  // a response is much narrower than an address beat, so it is padded up to
  // the record width
  localparam int resp_pad_width =
    $bits(axi_tap_pkg::axi_addr_t) - $bits(axi_tap_pkg::axi_resp_t);

  // response view of a record, pad on top and the response in the low bits
  typedef struct packed {
    logic [resp_pad_width-1:0] pad;
    axi_tap_pkg::axi_resp_t    beat;
  } resp_view_t;

  // the record word is read as an address beat or as a response,
  // depending on the tag that travels with it
  typedef union packed {
    axi_tap_pkg::axi_addr_t addr;
    resp_view_t             resp;
  } record_t;

  // stream tdata, tag in the top two bits
  typedef struct packed {
    channel_t tag;
    record_t  record;
  } stream_word_t;

endpackage

// ==== logic/addr_channel_tap.sv ====
`timescale 1ns/100ps

module addr_channel_tap #(
  parameter stream_pkg::channel_t channel = stream_pkg::chan_ar
) (
  input  logic                     clk,
  input  logic                     resetn,
  // subordinate side, the manager drives the beat in here
  input  axi_tap_pkg::axi_addr_t   s_addr,
  input  logic                     s_valid,
  output logic                     s_ready,
  // manager side, towards the downstream subordinate
  output axi_tap_pkg::axi_addr_t   m_addr,
  output logic                     m_valid,
  input  logic                     m_ready,
  // record exchange with the arbiter
  input  logic                     taken,
  output logic                     pending,
  output stream_pkg::stream_word_t record
);

  logic handshake;

  // the beat goes through untouched
  // while a record waits for the arbiter the channel is held off on both sides
  assign m_addr  = s_addr;
  assign m_valid = s_valid && !pending;
  assign s_ready = m_ready && !pending;

  assign handshake = s_valid && s_ready;

  // a handshake cannot happen while pending is high, so set and clear never meet
  always_ff @(posedge clk) begin
    if (resetn) begin
      pending <= 1'b0;
    end else if (handshake) begin
      pending <= 1'b1;
    end else if (taken) begin
      pending <= 1'b0;
    end
  end

  // capture the completed beat as an address record
  always_ff @(posedge clk) begin
    if (handshake) begin
      record.tag         <= channel;
      record.record.addr <= s_addr;
    end
  end

  // the stall must really keep the channel quiet until the arbiter takes the record
  a_no_handshake_pending: assert property (
    @(posedge clk) disable iff (resetn)
    pending |-> !handshake
  );

endmodule

// ==== logic/resp_channel_tap.sv ====
`timescale 1ns/100ps

module resp_channel_tap (
  input  logic                     clk,
  input  logic                     resetn,
  // manager side, the response comes back from the downstream subordinate
  input  axi_tap_pkg::axi_resp_t   m_resp,
  input  logic                     m_valid,
  output logic                     m_ready,
  // subordinate side, towards the original manager
  output axi_tap_pkg::axi_resp_t   s_resp,
  output logic                     s_valid,
  input  logic                     s_ready,
  // record exchange with the arbiter
  input  logic                     taken,
  output logic                     pending,
  output stream_pkg::stream_word_t record
);

  logic handshake;

  // B flows the other way round, so valid comes in on the manager side
  assign s_resp  = m_resp;
  assign s_valid = m_valid && !pending;
  assign m_ready = s_ready && !pending;

  assign handshake = m_valid && m_ready;

  always_ff @(posedge clk) begin
    if (resetn) begin
      pending <= 1'b0;
    end else if (handshake) begin
      pending <= 1'b1;
    end else if (taken) begin
      pending <= 1'b0;
    end
  end

  // the pad is cleared so the upper record bits are defined on the stream
  always_ff @(posedge clk) begin
    if (handshake) begin
      record.tag              <= stream_pkg::chan_b;
      record.record.resp.pad  <= '0;
      record.record.resp.beat <= m_resp;
    end
  end

  a_no_handshake_pending: assert property (
    @(posedge clk) disable iff (resetn)
    pending |-> !handshake
  );

endmodule

// ==== logic/stream_arbiter.sv ====
`timescale 1ns/100ps

module stream_arbiter (
  input  logic                                                clk,
  input  logic                                                resetn,
  input  logic [stream_pkg::num_channels-1:0]                 pending,
  input  stream_pkg::stream_word_t [stream_pkg::num_channels-1:0] records,
  output logic [stream_pkg::num_channels-1:0]                 taken,
  output stream_pkg::stream_word_t                            tdata,
  output logic                                                tvalid,
  output logic                                                tlast,
  input  logic                                                tready
);

  // last channel served, the search starts one past it
  stream_pkg::channel_t ptr;
  stream_pkg::channel_t sel;
  logic                 stream_hs;

  // step to the next channel, wrapping after B
  function automatic stream_pkg::channel_t next_chan(stream_pkg::channel_t c);
    case (c)
      stream_pkg::chan_ar: return stream_pkg::chan_aw;
      stream_pkg::chan_aw: return stream_pkg::chan_b;
      default:             return stream_pkg::chan_ar;
    endcase
  endfunction

  // round-robin search, the first pending channel after ptr wins
  always_comb begin
    stream_pkg::channel_t cand;
    logic                 found;
    cand  = next_chan(ptr);
    sel   = cand;
    found = 1'b0;
    for (int i = 0; i < stream_pkg::num_channels; i++) begin
      if (!found && pending[cand]) begin
        sel   = cand;
        found = 1'b1;
      end
      cand = next_chan(cand);
    end
  end

  // every record is a single beat, so each valid beat is also the last one
  assign tvalid    = |pending;
  assign tlast     = tvalid;
  assign tdata     = records[sel];
  assign stream_hs = tvalid && tready;

  always_comb begin
    taken = '0;
    if (stream_hs) begin
      taken[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (resetn) begin
      ptr <= stream_pkg::chan_b;
    end else if (stream_hs) begin
      ptr <= sel;
    end
  end

  a_taken_onehot: assert property (
    @(posedge clk) disable iff (resetn)
    $onehot0(taken)
  );

  a_taken_ready: assert property (
    @(posedge clk) disable iff (resetn)
    |taken |-> tready
  );

  // under back-pressure the beat may only change when another tap turns pending
  a_tdata_hold: assert property (
    @(posedge clk) disable iff (resetn)
    (tvalid && !tready) ##1 (pending == $past(pending)) |-> tvalid && $stable(tdata)
  );

endmodule

// ==== logic/axi_stream_tap.sv ====
`timescale 1ns/100ps

module axi_stream_tap (
  input  logic                     clk,
  input  logic                     resetn,
  // AR
  input  axi_tap_pkg::axi_addr_t   s_ar,
  input  logic                     s_ar_valid,
  output logic                     s_ar_ready,
  output axi_tap_pkg::axi_addr_t   m_ar,
  output logic                     m_ar_valid,
  input  logic                     m_ar_ready,
  // AW
  input  axi_tap_pkg::axi_addr_t   s_aw,
  input  logic                     s_aw_valid,
  output logic                     s_aw_ready,
  output axi_tap_pkg::axi_addr_t   m_aw,
  output logic                     m_aw_valid,
  input  logic                     m_aw_ready,
  // B, from the manager side back to the subordinate side
  input  axi_tap_pkg::axi_resp_t   m_b,
  input  logic                     m_b_valid,
  output logic                     m_b_ready,
  output axi_tap_pkg::axi_resp_t   s_b,
  output logic                     s_b_valid,
  input  logic                     s_b_ready,
  // record stream
  output stream_pkg::stream_word_t tdata,
  output logic                     tvalid,
  output logic                     tlast,
  input  logic                     tready
);

  logic [stream_pkg::num_channels-1:0]                     pending;
  logic [stream_pkg::num_channels-1:0]                     taken;
  stream_pkg::stream_word_t [stream_pkg::num_channels-1:0] records;

  addr_channel_tap #(
    .channel(stream_pkg::chan_ar)
  ) i_ar_tap (
    .clk     (clk),
    .resetn  (resetn),
    .s_addr  (s_ar),
    .s_valid (s_ar_valid),
    .s_ready (s_ar_ready),
    .m_addr  (m_ar),
    .m_valid (m_ar_valid),
    .m_ready (m_ar_ready),
    .taken   (taken[stream_pkg::chan_ar]),
    .pending (pending[stream_pkg::chan_ar]),
    .record  (records[stream_pkg::chan_ar])
  );

  addr_channel_tap #(
    .channel(stream_pkg::chan_aw)
  ) i_aw_tap (
    .clk     (clk),
    .resetn  (resetn),
    .s_addr  (s_aw),
    .s_valid (s_aw_valid),
    .s_ready (s_aw_ready),
    .m_addr  (m_aw),
    .m_valid (m_aw_valid),
    .m_ready (m_aw_ready),
    .taken   (taken[stream_pkg::chan_aw]),
    .pending (pending[stream_pkg::chan_aw]),
    .record  (records[stream_pkg::chan_aw])
  );

  resp_channel_tap i_b_tap (
    .clk     (clk),
    .resetn  (resetn),
    .m_resp  (m_b),
    .m_valid (m_b_valid),
    .m_ready (m_b_ready),
    .s_resp  (s_b),
    .s_valid (s_b_valid),
    .s_ready (s_b_ready),
    .taken   (taken[stream_pkg::chan_b]),
    .pending (pending[stream_pkg::chan_b]),
    .record  (records[stream_pkg::chan_b])
  );

  stream_arbiter i_arbiter (
    .clk     (clk),
    .resetn  (resetn),
    .pending (pending),
    .records (records),
    .taken   (taken),
    .tdata   (tdata),
    .tvalid  (tvalid),
    .tlast   (tlast),
    .tready  (tready)
  );

endmodule

// ==== tb/tb_tap_checks.svh ====
`ifndef TB_TAP_CHECKS_SVH
`define TB_TAP_CHECKS_SVH

  // expected stream word for one captured beat
  // an address record fills the whole record, a response sits under a zero pad
  function automatic stream_pkg::stream_word_t expect_word(
    input stream_pkg::channel_t   tag,
    input axi_tap_pkg::axi_addr_t addr,
    input axi_tap_pkg::axi_resp_t resp
  );
    stream_pkg::stream_word_t w;
    w     = '0;
    w.tag = tag;
    if (tag == stream_pkg::chan_b) begin
      w.record.resp.pad  = '0;
      w.record.resp.beat = resp;
    end else begin
      w.record.addr = addr;
    end
    return w;
  endfunction

  // compares one value against its expected value and stops at the first mismatch
  task automatic check_value(
    input string       what,
    input logic [63:0] expected,
    input logic [63:0] actual
  );
    if (expected !== actual) begin
      $display("CHECK FAILED: test %s, %s: expected %h, actual %h",
               test_name, what, expected, actual);
      stop_on_error();
    end
  endtask

`endif

// ==== tb/tb_axi_stream_tap.sv ====
`timescale 1ns/100ps

module tb_axi_stream_tap;

  localparam int clk_period    = 100;
  localparam int reset_cycles  = 5;
  localparam int random_cycles = 300;
  // eight directed transactions, then at most one per channel and cycle of random traffic
  localparam int num_transactions = 8 + random_cycles;
  localparam int watchdog_cycles  = 20 * num_transactions + 2 * reset_cycles;

  logic                     clk;
  logic                     resetn;
  axi_tap_pkg::axi_addr_t   s_ar, m_ar, s_aw, m_aw;
  logic                     s_ar_valid, s_ar_ready, m_ar_valid, m_ar_ready;
  logic                     s_aw_valid, s_aw_ready, m_aw_valid, m_aw_ready;
  axi_tap_pkg::axi_resp_t   m_b, s_b;
  logic                     m_b_valid, m_b_ready, s_b_valid, s_b_ready;
  stream_pkg::stream_word_t tdata;
  logic                     tvalid, tlast, tready;

  integer                   seed;
  string                    test_name;
  int                       ar_hs_count, aw_hs_count, b_hs_count;
  stream_pkg::stream_word_t q_ar[$], q_aw[$], q_b[$];
  stream_pkg::channel_t     seen_tags[$], want_tags[$];

  axi_stream_tap i_dut (
    .clk        (clk),
    .resetn     (resetn),
    .s_ar       (s_ar),
    .s_ar_valid (s_ar_valid),
    .s_ar_ready (s_ar_ready),
    .m_ar       (m_ar),
    .m_ar_valid (m_ar_valid),
    .m_ar_ready (m_ar_ready),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_b        (m_b),
    .m_b_valid  (m_b_valid),
    .m_b_ready  (m_b_ready),
    .s_b        (s_b),
    .s_b_valid  (s_b_valid),
    .s_b_ready  (s_b_ready),
    .tdata      (tdata),
    .tvalid     (tvalid),
    .tlast      (tlast),
    .tready     (tready)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic stop_on_error();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  `include "tb_tap_checks.svh"

  function automatic axi_tap_pkg::axi_addr_t random_addr();
    axi_tap_pkg::axi_addr_t a;
    logic [31:0]            r;
    r       = $random(seed);
    a.addr  = r;
    r       = $random(seed);
    a.id    = r[3:0];
    a.len   = r[11:4];
    a.size  = r[14:12];
    a.burst = r[16:15];
    return a;
  endfunction

  function automatic axi_tap_pkg::axi_resp_t random_resp();
    axi_tap_pkg::axi_resp_t b;
    logic [31:0]            r;
    r      = $random(seed);
    b.id   = r[3:0];
    b.resp = r[5:4];
    return b;
  endfunction

  // every AXI handshake is checked on both sides and queued as an expected record
  always @(posedge clk) begin
    if (!resetn) begin
      check_value("ar handshake on both sides", 64'(s_ar_valid && s_ar_ready),
                  64'(m_ar_valid && m_ar_ready));
      check_value("aw handshake on both sides", 64'(s_aw_valid && s_aw_ready),
                  64'(m_aw_valid && m_aw_ready));
      check_value("b handshake on both sides", 64'(m_b_valid && m_b_ready),
                  64'(s_b_valid && s_b_ready));
      if (m_ar_valid && m_ar_ready) begin
        check_value("m_ar pass-through", 64'(s_ar), 64'(m_ar));
        q_ar.push_back(expect_word(stream_pkg::chan_ar, s_ar, '0));
        ar_hs_count++;
      end
      if (m_aw_valid && m_aw_ready) begin
        check_value("m_aw pass-through", 64'(s_aw), 64'(m_aw));
        q_aw.push_back(expect_word(stream_pkg::chan_aw, s_aw, '0));
        aw_hs_count++;
      end
      if (s_b_valid && s_b_ready) begin
        check_value("s_b pass-through", 64'(m_b), 64'(s_b));
        q_b.push_back(expect_word(stream_pkg::chan_b, '0, m_b));
        b_hs_count++;
      end
    end
  end

  // compare process, each stream beat is matched against the queue of its tag
  always @(posedge clk) begin
    stream_pkg::stream_word_t exp;
    if (!resetn && tvalid && tready) begin
      check_value("tlast on a single-beat record", 64'(1), 64'(tlast));
      seen_tags.push_back(tdata.tag);
      case (tdata.tag)
        stream_pkg::chan_ar: begin
          if (q_ar.size() == 0) begin
            $display("stream beat tagged AR arrived without an AR handshake");
            stop_on_error();
          end
          exp = q_ar.pop_front();
          check_value("ar record", 64'(exp), 64'(tdata));
        end
        stream_pkg::chan_aw: begin
          if (q_aw.size() == 0) begin
            $display("stream beat tagged AW arrived without an AW handshake");
            stop_on_error();
          end
          exp = q_aw.pop_front();
          check_value("aw record", 64'(exp), 64'(tdata));
        end
        stream_pkg::chan_b: begin
          if (q_b.size() == 0) begin
            $display("stream beat tagged B arrived without a B handshake");
            stop_on_error();
          end
          exp = q_b.pop_front();
          check_value("b record", 64'(exp), 64'(tdata));
        end
        default: begin
          $display("stream beat carries an unknown channel tag");
          stop_on_error();
        end
      endcase
    end
  end

  // tasks below start and end on a falling edge
  task automatic apply_reset();
    resetn = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    resetn = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    seen_tags.delete();
    want_tags.delete();
  endtask

  task automatic send_ar(input axi_tap_pkg::axi_addr_t beat);
    int start;
    start      = ar_hs_count;
    s_ar       = beat;
    s_ar_valid = 1'b1;
    @(negedge clk);
    while (ar_hs_count == start) @(negedge clk);
    s_ar_valid = 1'b0;
  endtask

  task automatic send_aw(input axi_tap_pkg::axi_addr_t beat);
    int start;
    start      = aw_hs_count;
    s_aw       = beat;
    s_aw_valid = 1'b1;
    @(negedge clk);
    while (aw_hs_count == start) @(negedge clk);
    s_aw_valid = 1'b0;
  endtask

  task automatic send_b(input axi_tap_pkg::axi_resp_t beat);
    int start;
    start     = b_hs_count;
    m_b       = beat;
    m_b_valid = 1'b1;
    @(negedge clk);
    while (b_hs_count == start) @(negedge clk);
    m_b_valid = 1'b0;
  endtask

  task automatic drain();
    while (q_ar.size() != 0 || q_aw.size() != 0 || q_b.size() != 0 || tvalid) begin
      @(negedge clk);
    end
  endtask

  task automatic check_order();
    check_value("number of stream beats", 64'(want_tags.size()), 64'(seen_tags.size()));
    for (int i = 0; i < want_tags.size(); i++) begin
      check_value("tag order", 64'(want_tags[i]), 64'(seen_tags[i]));
    end
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    int          ar_last;
    int          aw_last;
    int          b_last;
    ar_last = ar_hs_count;
    aw_last = aw_hs_count;
    b_last  = b_hs_count;
    for (int cyc = 0; cyc < random_cycles; cyc++) begin
      r = $random(seed);
      // a beat stays on the bus until its handshake, readys change freely
      if (!s_ar_valid || ar_hs_count != ar_last) begin
        s_ar       = random_addr();
        s_ar_valid = r[0];
      end
      if (!s_aw_valid || aw_hs_count != aw_last) begin
        s_aw       = random_addr();
        s_aw_valid = r[1];
      end
      if (!m_b_valid || b_hs_count != b_last) begin
        m_b       = random_resp();
        m_b_valid = r[2];
      end
      m_ar_ready = r[3];
      m_aw_ready = r[4];
      s_b_ready  = r[5];
      tready     = r[6];
      ar_last    = ar_hs_count;
      aw_last    = aw_hs_count;
      b_last     = b_hs_count;
      @(negedge clk);
    end
    m_ar_ready = 1'b1;
    m_aw_ready = 1'b1;
    s_b_ready  = 1'b1;
    tready     = 1'b1;
    while (s_ar_valid || s_aw_valid || m_b_valid) begin
      if (ar_hs_count != ar_last) s_ar_valid = 1'b0;
      if (aw_hs_count != aw_last) s_aw_valid = 1'b0;
      if (b_hs_count != b_last) m_b_valid = 1'b0;
      ar_last = ar_hs_count;
      aw_last = aw_hs_count;
      b_last  = b_hs_count;
      @(negedge clk);
    end
  endtask

  initial begin
    clk         = 1'b0;
    resetn      = 1'b1;
    seed        = 32'h9be0;
    s_ar        = '0;
    s_ar_valid  = 1'b0;
    m_ar_ready  = 1'b1;
    s_aw        = '0;
    s_aw_valid  = 1'b0;
    m_aw_ready  = 1'b1;
    m_b         = '0;
    m_b_valid   = 1'b0;
    s_b_ready   = 1'b1;
    tready      = 1'b1;
    test_name   = "reset";
    ar_hs_count = 0;
    aw_hs_count = 0;
    b_hs_count  = 0;
    @(negedge clk);
    apply_reset();

    start_test("ar_pass_through");
    send_ar(random_addr());
    drain();
    want_tags = '{stream_pkg::chan_ar};
    check_order();

    start_test("aw_pass_through");
    send_aw(random_addr());
    drain();
    want_tags = '{stream_pkg::chan_aw};
    check_order();

    start_test("b_pass_through");
    send_b(random_resp());
    drain();
    want_tags = '{stream_pkg::chan_b};
    check_order();

    // after reset the search starts at AR, so the backlog leaves in channel order
    start_test("round_robin");
    apply_reset();
    tready = 1'b0;
    send_ar(random_addr());
    send_aw(random_addr());
    send_b(random_resp());
    tready = 1'b1;
    drain();
    want_tags = '{stream_pkg::chan_ar, stream_pkg::chan_aw, stream_pkg::chan_b};
    check_order();

    start_test("back_pressure");
    tready = 1'b0;
    send_ar(random_addr());
    begin
      int start;
      start      = ar_hs_count;
      s_ar       = random_addr();
      s_ar_valid = 1'b1;
      repeat (3) begin
        @(negedge clk);
        check_value("s_ar_ready while stalled", 64'(0), 64'(s_ar_ready));
        check_value("m_ar_valid while stalled", 64'(0), 64'(m_ar_valid));
        check_value("ar handshakes while stalled", 64'(start), 64'(ar_hs_count));
      end
      tready = 1'b1;
      while (ar_hs_count == start) @(negedge clk);
      s_ar_valid = 1'b0;
    end
    drain();
    want_tags = '{stream_pkg::chan_ar, stream_pkg::chan_ar};
    check_order();

    start_test("random_traffic");
    random_traffic();
    drain();

    if (q_ar.size() == 0 && q_aw.size() == 0 && q_b.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("records were left unmatched at the end of the run");
      stop_on_error();
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired, the tests did not finish within %0d cycles", watchdog_cycles);
    stop_on_error();
  end

endmodule

// ==== axi_stream_tap.f ====
+incdir+tb
common/axi_tap_pkg.sv
common/stream_pkg.sv
logic/addr_channel_tap.sv
logic/resp_channel_tap.sv
logic/stream_arbiter.sv
logic/axi_stream_tap.sv
tb/tb_axi_stream_tap.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
# the exit status of the simulation gives pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axi_stream_tap \
  -f axi_stream_tap.f

./obj_dir/Vtb_axi_stream_tap
